// ==== hdl/csr_arbiter.sv ====
// Round-robin arbiter sharing one CSR bus between two four-phase requesters
`timescale 1ns/1ps
`default_nettype none

module csr_arbiter (
  input  logic                     CLK,
  input  logic                     nRST,
  input  logic                     i_a_req,
  input  logic [11:0]              i_a_addr,
  input  logic                     i_a_we,
  input  logic [pmp_pkg::XLEN-1:0] i_a_wdata,
  output logic                     o_a_ack,
  output logic [pmp_pkg::XLEN-1:0] o_a_rdata,
  output logic                     o_a_err,
  input  logic                     i_b_req,
  input  logic [11:0]              i_b_addr,
  input  logic                     i_b_we,
  input  logic [pmp_pkg::XLEN-1:0] i_b_wdata,
  output logic                     o_b_ack,
  output logic [pmp_pkg::XLEN-1:0] o_b_rdata,
  output logic                     o_b_err,
  csr_bus_if.requester             bus
);

  logic busy;      // A grant is held
  logic sel;       // 0 grants port a, 1 grants port b
  logic last;      // Port served by the previous grant
  logic seen_ack;  // Bus ack was high during this grant
  logic sel_req;

  assign sel_req = sel ? i_b_req : i_a_req;

  // Once ack has come and gone the request is masked until release
  assign bus.req   = busy & sel_req & (~seen_ack | bus.ack);
  assign bus.addr  = sel ? i_b_addr  : i_a_addr;
  assign bus.we    = sel ? i_b_we    : i_a_we;
  assign bus.wdata = sel ? i_b_wdata : i_a_wdata;

  assign o_a_ack   = busy & ~sel & bus.ack;
  assign o_b_ack   = busy &  sel & bus.ack;
  assign o_a_rdata = bus.rdata;
  assign o_b_rdata = bus.rdata;
  assign o_a_err   = bus.err;
  assign o_b_err   = bus.err;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      busy     <= 1'b0;
      sel      <= 1'b0;
      last     <= 1'b0;
      seen_ack <= 1'b0;
    end else if (!busy) begin
      if (i_a_req || i_b_req) begin
        busy     <= 1'b1;
        sel      <= (i_a_req && i_b_req) ? ~last : i_b_req;  // Alternate on a tie
        seen_ack <= 1'b0;
      end
    end else if (bus.ack) begin
      seen_ack <= 1'b1;
    end else if (seen_ack) begin
      busy     <= 1'b0;  // Full handshake done
      last     <= sel;
      seen_ack <= 1'b0;
    end
  end

  // Grant is held across the whole four-phase exchange
  a_grant_held: assert property (@(posedge CLK) disable iff (!nRST)
    (bus.req || bus.ack) |=> (busy && $stable(sel)));

endmodule

`default_nettype wire

// ==== hdl/csr_bus_if.sv ====
// CSR request/response channel with four-phase handshake, requester and responder modports
`timescale 1ns/1ps
`default_nettype none

interface csr_bus_if;

  // Request side, held stable while req is high
  logic                     req;
  logic [11:0]              addr;
  logic                     we;
  logic [pmp_pkg::XLEN-1:0] wdata;

  // Response side, valid while ack is high
  logic                     ack;
  logic [pmp_pkg::XLEN-1:0] rdata;
  logic                     err;  // Address outside both CSR ranges

  modport requester (
    output req, addr, we, wdata,
    input  ack, rdata, err
  );

  modport responder (
    input  req, addr, we, wdata,
    output ack, rdata, err
  );

endinterface

`default_nettype wire

// ==== hdl/pmp_checker.sv ====
// PMP permission checker with per-entry matchers, lowest-index priority and privilege rule
`timescale 1ns/1ps
`default_nettype none

module pmp_checker #(
  parameter int NUM_ENTRIES = 16
) (
  input  logic [pmp_pkg::PADDR_W-1:0]                   i_addr,
  input  pmp_pkg::pmp_priv_t                            i_priv,
  input  pmp_pkg::pmp_cfg_word_u [NUM_ENTRIES/4-1:0]    i_cfg,
  input  logic [NUM_ENTRIES-1:0][pmp_pkg::XLEN-1:0]     i_addr_regs,
  input  logic                                          i_rd,
  input  logic                                          i_wr,
  input  logic                                          i_ex,
  output logic                                          o_fault
);

  pmp_pkg::pmp_entry_t [NUM_ENTRIES-1:0]         ent;
  logic [NUM_ENTRIES-1:0][pmp_pkg::XLEN-1:0]     prev_regs;  // prev_regs[i] is pmpaddr i-1
  logic [NUM_ENTRIES-1:0]                        match;
  pmp_pkg::pmp_entry_t                           sel;
  logic                                          hit;
  logic                                          deny;

  assign ent       = i_cfg;
  assign prev_regs = {i_addr_regs[NUM_ENTRIES-2:0], {pmp_pkg::XLEN{1'b0}}};

  for (genvar g = 0; g < NUM_ENTRIES; g++) begin : g_match
    pmp_matcher matcher_inst (
      .i_addr         (i_addr),
      .i_entry        (ent[g]),
      .i_pmpaddr      (i_addr_regs[g]),
      .i_prev_pmpaddr (prev_regs[g]),
      .o_match        (match[g])
    );
  end

  // Walk from the top so the lowest matching index wins
  always_comb begin
    hit = 1'b0;
    sel = '0;
    for (int k = NUM_ENTRIES - 1; k >= 0; k--) begin
      if (match[k]) begin
        hit = 1'b1;
        sel = ent[k];
      end
    end
  end

  assign deny = (i_rd & ~sel.r) | (i_wr & ~sel.w) | (i_ex & ~sel.x);

  always_comb begin
    if (i_priv != pmp_pkg::M_MODE) begin
      o_fault = !hit || deny;  // No match below M is a fault
    end else begin
      o_fault = hit && sel.l && deny;  // M-mode only obeys locked entries
    end
  end

endmodule

`default_nettype wire

// ==== hdl/pmp_csr_file.sv ====
// PMP configuration and address registers with WARL and lock rules, readback and error flag
`timescale 1ns/1ps
`default_nettype none

module pmp_csr_file #(
  parameter int NUM_ENTRIES = 16
) (
  input  logic                                             CLK,
  input  logic                                             nRST,
  csr_bus_if.responder                                     bus,
  output pmp_pkg::pmp_cfg_word_u [NUM_ENTRIES/4-1:0]       o_cfg,
  output logic [NUM_ENTRIES-1:0][pmp_pkg::XLEN-1:0]        o_addr
);

  localparam int NUM_CFG = NUM_ENTRIES / 4;
  localparam int CW      = (NUM_CFG > 1) ? $clog2(NUM_CFG) : 1;
  localparam int AW      = $clog2(NUM_ENTRIES);

  pmp_pkg::pmp_cfg_word_u [NUM_CFG-1:0]           cfg_q;
  logic [NUM_ENTRIES-1:0][pmp_pkg::XLEN-1:0]      addr_q;
  pmp_pkg::pmp_entry_t [NUM_ENTRIES-1:0]          ent;  // Flat view, ent[i] is entry i
  pmp_pkg::pmp_cfg_word_u                         new_cfg;

  logic          cfg_hit;
  logic          addr_hit;
  logic [CW-1:0] cfg_idx;
  logic [AW-1:0] addr_idx;
  logic [AW-1:0] nxt_idx;
  logic          addr_lock;

  assign ent    = cfg_q;
  assign o_cfg  = cfg_q;
  assign o_addr = addr_q;

  // Both bases are 16-aligned so the low address bits index directly
  assign cfg_hit  = (bus.addr >= pmp_pkg::PMPCFG_BASE) &&
                    (bus.addr <  pmp_pkg::PMPCFG_BASE + NUM_CFG);
  assign addr_hit = (bus.addr >= pmp_pkg::PMPADDR_BASE) &&
                    (bus.addr <  pmp_pkg::PMPADDR_BASE + NUM_ENTRIES);
  assign cfg_idx  = bus.addr[CW-1:0];
  assign addr_idx = bus.addr[AW-1:0];
  assign nxt_idx  = addr_idx + 1'b1;

  // Write value of a pmpcfg CSR, byte by byte
  always_comb begin
    new_cfg.word = bus.wdata;
    for (int k = 0; k < 4; k++) begin
      new_cfg.entry[k].rsvd = 2'b00;
      if (!new_cfg.entry[k].w) begin
        new_cfg.entry[k].r = 1'b0;  // R=1 W=0 is reserved
      end
      if (cfg_q[cfg_idx].entry[k].l) begin
        new_cfg.entry[k] = cfg_q[cfg_idx].entry[k];  // Locked byte keeps its value
      end
    end
  end

  // pmpaddr i is also top of range for entry i+1 in TOR mode
  always_comb begin
    addr_lock = ent[addr_idx].l;
    if (addr_idx != AW'(NUM_ENTRIES - 1)) begin
      if (ent[nxt_idx].a == pmp_pkg::TOR && ent[nxt_idx].l) begin
        addr_lock = 1'b1;
      end
    end
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      cfg_q     <= '0;
      addr_q    <= '0;
      bus.ack   <= 1'b0;
      bus.rdata <= '0;
      bus.err   <= 1'b0;
    end else if (bus.ack) begin
      if (!bus.req) begin
        bus.ack <= 1'b0;
      end
    end else if (bus.req) begin
      bus.ack <= 1'b1;
      bus.err <= !(cfg_hit || addr_hit);
      // Read returns the value from before the write
      if (cfg_hit) begin
        bus.rdata <= cfg_q[cfg_idx].word;
      end else if (addr_hit) begin
        bus.rdata <= addr_q[addr_idx];
      end else begin
        bus.rdata <= '0;
      end
      if (bus.we && cfg_hit) begin
        cfg_q[cfg_idx] <= new_cfg;
      end
      if (bus.we && addr_hit && !addr_lock) begin
        addr_q[addr_idx] <= bus.wdata;
      end
    end
  end

  a_ack_needs_req: assert property (@(posedge CLK) disable iff (!nRST)
    $rose(bus.ack) |-> $past(bus.req));

  // Lock is sticky until reset, so nothing of a locked entry may move
  for (genvar g = 0; g < NUM_ENTRIES; g++) begin : g_lock_chk
    a_locked_stable: assert property (@(posedge CLK) disable iff (!nRST)
      ent[g].l |=> ($stable(ent[g]) && $stable(addr_q[g])));
  end

endmodule

`default_nettype wire

// ==== hdl/pmp_matcher.sv ====
// Address match of one PMP entry for OFF, TOR, NA4 and NAPOT modes
`timescale 1ns/1ps
`default_nettype none

module pmp_matcher (
  input  logic [pmp_pkg::PADDR_W-1:0] i_addr,
  input  pmp_pkg::pmp_entry_t         i_entry,
  input  logic [pmp_pkg::XLEN-1:0]    i_pmpaddr,
  input  logic [pmp_pkg::XLEN-1:0]    i_prev_pmpaddr,  // Zero for entry 0
  output logic                        o_match
);

  logic [pmp_pkg::XLEN-1:0] word;        // Address in 4-byte units
  logic [pmp_pkg::XLEN-1:0] napot_mask;

  assign word = i_addr[pmp_pkg::PADDR_W-1:2];

  // x ^ (x+1) sets the trailing ones and the first zero above them,
  // which is exactly the span of the NAPOT region
  assign napot_mask = ~(i_pmpaddr ^ (i_pmpaddr + 1'b1));

  always_comb begin
    o_match = 1'b0;
    case (i_entry.a)
      pmp_pkg::OFF: begin
        o_match = 1'b0;
      end
      pmp_pkg::TOR: begin
        o_match = (i_prev_pmpaddr <= word) && (word < i_pmpaddr);
      end
      pmp_pkg::NA4: begin
        o_match = (word == i_pmpaddr);
      end
      pmp_pkg::NAPOT: begin
        o_match = ((word ^ i_pmpaddr) & napot_mask) == '0;  // All ones covers everything
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/pmp_pkg.sv ====
// PMP entry types, configuration word union, address modes, privilege codes and CSR bases
`default_nettype none

package pmp_pkg;

  localparam int XLEN    = 32;
  localparam int PADDR_W = 34;  // Physical address, pmpaddr holds bits 33..2

  localparam logic [11:0] PMPCFG_BASE  = 12'h3A0;
  localparam logic [11:0] PMPADDR_BASE = 12'h3B0;

  // Address matching mode of one entry
  typedef enum logic [1:0] {
    OFF   = 2'd0,
    TOR   = 2'd1,
    NA4   = 2'd2,
    NAPOT = 2'd3
  } pmp_amode_t;

  // One configuration byte, MSB first
  typedef struct packed {
    logic       l;
    logic [1:0] rsvd;
    pmp_amode_t a;
    logic       x;
    logic       w;
    logic       r;
  } pmp_entry_t;

  // A pmpcfg CSR seen as a raw word or as four entry bytes
  typedef union packed {
    logic [XLEN-1:0]  word;
    pmp_entry_t [3:0] entry;  // entry[0] sits in bits 7..0
  } pmp_cfg_word_u;

  // Privilege levels, encoding 2'b10 is reserved
  typedef enum logic [1:0] {
    U_MODE = 2'b00,
    S_MODE = 2'b01,
    M_MODE = 2'b11
  } pmp_priv_t;

endpackage

`default_nettype wire

// ==== hdl/pmp_top.sv ====
// PMP unit top with two CSR ports, arbiter, register file and data and fetch checkers
`timescale 1ns/1ps
`default_nettype none

module pmp_top #(
  parameter int NUM_ENTRIES = 16
) (
  input  logic                        CLK,
  input  logic                        nRST,
  input  logic                        i_core_req,
  input  logic [11:0]                 i_core_addr,
  input  logic                        i_core_we,
  input  logic [pmp_pkg::XLEN-1:0]    i_core_wdata,
  output logic                        o_core_ack,
  output logic [pmp_pkg::XLEN-1:0]    o_core_rdata,
  output logic                        o_core_err,
  input  logic                        i_dbg_req,
  input  logic [11:0]                 i_dbg_addr,
  input  logic                        i_dbg_we,
  input  logic [pmp_pkg::XLEN-1:0]    i_dbg_wdata,
  output logic                        o_dbg_ack,
  output logic [pmp_pkg::XLEN-1:0]    o_dbg_rdata,
  output logic                        o_dbg_err,
  input  pmp_pkg::pmp_priv_t          i_priv,
  input  logic                        i_mprv,
  input  pmp_pkg::pmp_priv_t          i_mpp,
  input  logic [pmp_pkg::PADDR_W-1:0] i_daddr,
  input  logic                        i_ren,
  input  logic                        i_wen,
  output logic                        o_load_fault,
  output logic                        o_store_fault,
  input  logic [pmp_pkg::PADDR_W-1:0] i_iaddr,
  input  logic                        i_xen,
  output logic                        o_fetch_fault
);

  pmp_pkg::pmp_cfg_word_u [NUM_ENTRIES/4-1:0]    cfg;
  logic [NUM_ENTRIES-1:0][pmp_pkg::XLEN-1:0]     addr_regs;
  pmp_pkg::pmp_priv_t                            d_priv;
  logic                                          d_fault;
  logic                                          f_fault;

  csr_bus_if bus_if ();

  // Loads and stores run at MPP when MPRV is set, fetches never do
  assign d_priv = i_mprv ? i_mpp : i_priv;

  assign o_load_fault  = d_fault & i_ren;
  assign o_store_fault = d_fault & i_wen;
  assign o_fetch_fault = f_fault & i_xen;

  csr_arbiter arbiter_inst (
    .CLK       (CLK),
    .nRST      (nRST),
    .i_a_req   (i_core_req),
    .i_a_addr  (i_core_addr),
    .i_a_we    (i_core_we),
    .i_a_wdata (i_core_wdata),
    .o_a_ack   (o_core_ack),
    .o_a_rdata (o_core_rdata),
    .o_a_err   (o_core_err),
    .i_b_req   (i_dbg_req),
    .i_b_addr  (i_dbg_addr),
    .i_b_we    (i_dbg_we),
    .i_b_wdata (i_dbg_wdata),
    .o_b_ack   (o_dbg_ack),
    .o_b_rdata (o_dbg_rdata),
    .o_b_err   (o_dbg_err),
    .bus       (bus_if.requester)
  );

  pmp_csr_file #(.NUM_ENTRIES(NUM_ENTRIES)) csr_file_inst (
    .CLK    (CLK),
    .nRST   (nRST),
    .bus    (bus_if.responder),
    .o_cfg  (cfg),
    .o_addr (addr_regs)
  );

  pmp_checker #(.NUM_ENTRIES(NUM_ENTRIES)) data_chk (
    .i_addr      (i_daddr),
    .i_priv      (d_priv),
    .i_cfg       (cfg),
    .i_addr_regs (addr_regs),
    .i_rd        (i_ren),
    .i_wr        (i_wen),
    .i_ex        (1'b0),
    .o_fault     (d_fault)
  );

  pmp_checker #(.NUM_ENTRIES(NUM_ENTRIES)) fetch_chk (
    .i_addr      (i_iaddr),
    .i_priv      (i_priv),
    .i_cfg       (cfg),
    .i_addr_regs (addr_regs),
    .i_rd        (1'b0),
    .i_wr        (1'b0),
    .i_ex        (i_xen),
    .o_fault     (f_fault)
  );

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+verif
hdl/pmp_pkg.sv
hdl/csr_bus_if.sv
hdl/csr_arbiter.sv
hdl/pmp_csr_file.sv
hdl/pmp_matcher.sv
hdl/pmp_checker.sv
hdl/pmp_top.sv
verif/pmp_tb.sv

// ==== verif/pmp_model.svh ====
// Reference model of the PMP registers, write and lock rules, matching, fault rule and xorshift
`ifndef PMP_MODEL_SVH
`define PMP_MODEL_SVH

logic [7:0]  m_ent  [NUM_ENTRIES] = '{default: '0};  // L rsvd A X W R
logic [31:0] m_addr [NUM_ENTRIES] = '{default: '0};  // Physical address bits 33..2

function automatic logic [31:0] xorshift32(input logic [31:0] s);
  s = s ^ (s << 13);
  s = s ^ (s >> 17);
  s = s ^ (s << 5);
  return s;
endfunction

function automatic bit csr_addr_valid(input logic [11:0] a);
  return (a >= pmp_pkg::PMPCFG_BASE && a < pmp_pkg::PMPCFG_BASE + NUM_ENTRIES / 4) ||
         (a >= pmp_pkg::PMPADDR_BASE && a < pmp_pkg::PMPADDR_BASE + NUM_ENTRIES);
endfunction

function automatic logic [31:0] expected_read(input logic [11:0] a);
  int i;
  if (!csr_addr_valid(a)) begin
    return '0;  // Unknown CSR reads as zero with err
  end
  if (a < pmp_pkg::PMPADDR_BASE) begin
    i = int'(a - pmp_pkg::PMPCFG_BASE);
    return {m_ent[4*i+3], m_ent[4*i+2], m_ent[4*i+1], m_ent[4*i]};
  end
  i = int'(a - pmp_pkg::PMPADDR_BASE);
  return m_addr[i];
endfunction

function automatic void apply_csr_write(input logic [11:0] a, input logic [31:0] d);
  int i;
  logic [7:0] b;
  bit locked;
  if (!csr_addr_valid(a)) begin
    return;
  end
  if (a < pmp_pkg::PMPADDR_BASE) begin
    i = int'(a - pmp_pkg::PMPCFG_BASE);
    for (int k = 0; k < 4; k++) begin
      b = d[8*k +: 8];
      b[6:5] = 2'b00;  // Reserved bits
      if (!b[1]) begin
        b[0] = 1'b0;   // R without W is not kept
      end
      if (!m_ent[4*i+k][7]) begin
        m_ent[4*i+k] = b;
      end
    end
  end else begin
    i = int'(a - pmp_pkg::PMPADDR_BASE);
    locked = m_ent[i][7];
    // Locked TOR entry above also guards this register
    if (i < NUM_ENTRIES - 1 && m_ent[i+1][7] && m_ent[i+1][4:3] == 2'd1) begin
      locked = 1'b1;
    end
    if (!locked) begin
      m_addr[i] = d;
    end
  end
endfunction

function automatic bit entry_matches(input int i, input logic [33:0] pa);
  logic [31:0] w;
  logic [31:0] prev;
  int t;
  w = pa[33:2];
  prev = (i == 0) ? 32'd0 : m_addr[i-1];
  t = 0;
  case (m_ent[i][4:3])
    2'd1: return (prev <= w) && (w < m_addr[i]);
    2'd2: return w == m_addr[i];
    2'd3: begin
      while (t < 32 && m_addr[i][t]) begin
        t++;
      end
      if (t >= 31) begin
        return 1'b1;  // Region covers the whole space
      end
      return (w >> (t + 1)) == (m_addr[i] >> (t + 1));
    end
    default: return 1'b0;
  endcase
endfunction

function automatic bit expected_fault(input logic [33:0] pa, input logic [1:0] priv,
                                      input bit rd, input bit wr, input bit ex);
  logic [7:0] e;
  bit hit;
  bit deny;
  hit = 1'b0;
  e = '0;
  for (int i = 0; i < NUM_ENTRIES && !hit; i++) begin
    if (entry_matches(i, pa)) begin
      hit = 1'b1;
      e = m_ent[i];
    end
  end
  deny = (rd && !e[0]) || (wr && !e[1]) || (ex && !e[2]);
  if (priv != 2'b11) begin
    return !hit || deny;
  end
  return hit && e[7] && deny;  // M-mode obeys locked entries only
endfunction

`endif

// ==== verif/pmp_tb.sv ====
// Testbench for the PMP unit with random CSR traffic, access checks against a model and watchdog
`timescale 1ns/1ps
`default_nettype none

module pmp_tb;

  localparam int NUM_ENTRIES = 16;
  localparam int CLK_PERIOD  = 40;
  localparam int N_RULES     = 16;
  localparam int N_RAND      = 200;
  localparam int N_LOCK      = 4;
  localparam int N_LOCK_RAND = 50;
  localparam int N_ERR       = 6;
  localparam int N_ARB       = 8;
  localparam int N_OPS = 4 * N_RULES + 5 * NUM_ENTRIES + NUM_ENTRIES / 4 + N_RAND +
                         N_LOCK * (7 + N_LOCK_RAND) + N_ERR + NUM_ENTRIES + NUM_ENTRIES / 4 +
                         2 * N_ARB;
  localparam longint WATCHDOG_NS = longint'(N_OPS) * 40 * CLK_PERIOD + 16 * CLK_PERIOD;

  logic CLK;
  logic nRST;
  logic core_req, core_we, core_ack, core_err;
  logic [11:0] core_addr;
  logic [31:0] core_wdata, core_rdata;
  logic dbg_req, dbg_we, dbg_ack, dbg_err;
  logic [11:0] dbg_addr;
  logic [31:0] dbg_wdata, dbg_rdata;
  pmp_pkg::pmp_priv_t priv, mpp;
  logic mprv, ren, wen, xen;
  logic [33:0] daddr, iaddr;
  logic load_fault, store_fault, fetch_fault;

  logic [31:0] rng = 32'h293a_d080;
  int errs [3] = '{0, 0, 0};  // CSR, load/store, fetch
  logic [31:0] reg_val [NUM_ENTRIES];
  logic [31:0] lo_w [NUM_ENTRIES];  // Region bounds in words
  logic [31:0] hi_w [NUM_ENTRIES];

  `include "pmp_model.svh"

  pmp_top #(.NUM_ENTRIES(NUM_ENTRIES)) pmp_top_inst (
    .CLK (CLK), .nRST (nRST),
    .i_core_req (core_req), .i_core_addr (core_addr), .i_core_we (core_we),
    .i_core_wdata (core_wdata), .o_core_ack (core_ack), .o_core_rdata (core_rdata),
    .o_core_err (core_err),
    .i_dbg_req (dbg_req), .i_dbg_addr (dbg_addr), .i_dbg_we (dbg_we),
    .i_dbg_wdata (dbg_wdata), .o_dbg_ack (dbg_ack), .o_dbg_rdata (dbg_rdata),
    .o_dbg_err (dbg_err),
    .i_priv (priv), .i_mprv (mprv), .i_mpp (mpp),
    .i_daddr (daddr), .i_ren (ren), .i_wen (wen),
    .o_load_fault (load_fault), .o_store_fault (store_fault),
    .i_iaddr (iaddr), .i_xen (xen), .o_fetch_fault (fetch_fault)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  function automatic pmp_pkg::pmp_priv_t pick_priv(input logic [1:0] r);
    case (r)
      2'd0: return pmp_pkg::U_MODE;
      2'd1: return pmp_pkg::S_MODE;
      default: return pmp_pkg::M_MODE;
    endcase
  endfunction

  task automatic check_val(input int cat, input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
      errs[cat]++;
    end
  endtask

  // One four-phase exchange on the chosen port, 0 is core and 1 is debug
  task automatic csr_xfer(input bit port, input logic [11:0] a, input bit we,
                          input logic [31:0] d, output logic [31:0] rd, output logic err);
    @(posedge CLK);
    if (port) begin
      dbg_req   <= 1'b1;
      dbg_addr  <= a;
      dbg_we    <= we;
      dbg_wdata <= d;
    end else begin
      core_req   <= 1'b1;
      core_addr  <= a;
      core_we    <= we;
      core_wdata <= d;
    end
    @(negedge CLK);
    while (!(port ? dbg_ack : core_ack)) @(negedge CLK);
    rd  = port ? dbg_rdata : core_rdata;
    err = port ? dbg_err : core_err;
    @(posedge CLK);
    if (port) begin
      dbg_req <= 1'b0;
    end else begin
      core_req <= 1'b0;
    end
    @(negedge CLK);
    while (port ? dbg_ack : core_ack) @(negedge CLK);
  endtask

  task automatic csr_check(input bit port, input logic [11:0] a, input bit we,
                           input logic [31:0] d);
    logic [31:0] exp_rd;
    logic [31:0] got_rd;
    logic exp_err;
    logic got_err;
    exp_rd  = expected_read(a);  // Value from before the write
    exp_err = !csr_addr_valid(a);
    csr_xfer(port, a, we, d, got_rd, got_err);
    check_val(0, port ? "o_dbg_rdata" : "o_core_rdata", got_rd, exp_rd);
    check_val(0, port ? "o_dbg_err" : "o_core_err", got_err, exp_err);
    if (we) begin
      apply_csr_write(a, d);
    end
  endtask

  task automatic csr_any(input logic [11:0] a, input bit we, input logic [31:0] d);
    csr_check(next_rand() % 2 != 0, a, we, d);
  endtask

  task automatic drive_access(input logic [33:0] da, input logic [33:0] ia);
    logic [31:0] r;
    pmp_pkg::pmp_priv_t pv;
    pmp_pkg::pmp_priv_t pp;
    bit d_fault;
    bit f_fault;
    r  = next_rand();
    pv = pick_priv(r[1:0]);
    pp = pick_priv(r[3:2]);
    @(posedge CLK);
    priv  <= pv;
    mpp   <= pp;
    mprv  <= r[4];
    ren   <= r[5];
    wen   <= r[6];
    xen   <= r[7];
    daddr <= da;
    iaddr <= ia;
    @(negedge CLK);
    d_fault = expected_fault(da, r[4] ? pp : pv, r[5], r[6], 1'b0);
    f_fault = expected_fault(ia, pv, 1'b0, 1'b0, r[7]);  // MPRV has no effect on fetch
    check_val(1, "o_load_fault", load_fault, d_fault & r[5]);
    check_val(1, "o_store_fault", store_fault, d_fault & r[6]);
    check_val(2, "o_fetch_fault", fetch_fault, f_fault & r[7]);
  endtask

  // Word just outside or inside a bound of entry e, with a byte offset
  function automatic logic [33:0] near_bound(input int e, input int j, input logic [1:0] off);
    case (j)
      0: return {lo_w[e] - 32'd1, off};
      1: return {lo_w[e], off};
      2: return {hi_w[e], off};
      default: return {hi_w[e] + 32'd1, off};
    endcase
  endfunction

  task automatic random_accesses(input int n);
    logic [31:0] r;
    logic [33:0] da;
    logic [33:0] ia;
    repeat (n) begin
      r = next_rand();
      if (r[8]) begin
        da = {r[1:0], next_rand()};
        ia = {r[3:2], next_rand()};
      end else begin
        da = near_bound(int'(r[3:0]) % NUM_ENTRIES, int'(r[5:4]), r[7:6]);
        ia = near_bound(int'(r[12:9]) % NUM_ENTRIES, int'(r[14:13]), r[16:15]);
      end
      drive_access(da, ia);
    end
  endtask

  // TOR, NA4 and NAPOT regions, one 2^27-word slot per entry
  task automatic configure_regions();
    logic [31:0] r;
    logic [31:0] base;
    logic [31:0] span;
    logic [7:0] cfg_b [NUM_ENTRIES];
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      r = next_rand();
      base = (32'(i) << 27) + (r & 32'h03ff_fff0) + 32'h10;
      cfg_b[i] = {1'b0, r[31:30], r[1:0], r[4:2]};  // Random reserved bits too
      reg_val[i] = base;
      lo_w[i] = base;
      hi_w[i] = base;
      if (r[1:0] == 2'd1) begin
        lo_w[i] = (i == 0) ? 32'd0 : reg_val[i-1];
        hi_w[i] = base - 32'd1;
      end else if (r[1:0] == 2'd3) begin
        span = 32'd2 << (int'(r[23:20]) % 12);
        lo_w[i] = base & ~(span - 32'd1);
        hi_w[i] = lo_w[i] + span - 32'd1;
        reg_val[i] = lo_w[i] | ((span >> 1) - 32'd1);
      end
    end
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      csr_any(pmp_pkg::PMPADDR_BASE + 12'(i), 1'b1, reg_val[i]);
    end
    for (int c = 0; c < NUM_ENTRIES / 4; c++) begin
      csr_any(pmp_pkg::PMPCFG_BASE + 12'(c), 1'b1,
              {cfg_b[4*c+3], cfg_b[4*c+2], cfg_b[4*c+1], cfg_b[4*c]});
    end
  endtask

  task automatic lock_entry(input int n);
    int e;
    logic [11:0] ca;
    logic [11:0] aa;
    logic [31:0] d;
    logic [7:0] b;
    e  = next_rand() % NUM_ENTRIES;
    ca = pmp_pkg::PMPCFG_BASE + 12'(e / 4);
    aa = pmp_pkg::PMPADDR_BASE + 12'(e);
    d  = next_rand() & 32'h7f7f_7f7f;
    b  = d[8*(e%4) +: 8] | 8'h80;
    if (n % 2 == 0) begin
      b[4:3] = 2'd1;  // TOR, so pmpaddr e-1 gets locked as well
    end
    d[8*(e%4) +: 8] = b;
    csr_any(ca, 1'b1, d);
    csr_any(ca, 1'b1, next_rand());
    csr_any(aa, 1'b1, next_rand());
    csr_any(aa - 12'd1, 1'b1, next_rand());  // Below entry 0 this is an unknown CSR
    csr_any(ca, 1'b0, '0);
    csr_any(aa, 1'b0, '0);
    csr_any(aa - 12'd1, 1'b0, '0);
  endtask

  initial begin
    int j;
    int c;
    logic [11:0] a;
    logic [31:0] d;
    bit we;
    nRST = 1'b0;
    core_req = 1'b0;
    core_addr = '0;
    core_we = 1'b0;
    core_wdata = '0;
    dbg_req = 1'b0;
    dbg_addr = '0;
    dbg_we = 1'b0;
    dbg_wdata = '0;
    priv = pmp_pkg::M_MODE;
    mpp = pmp_pkg::U_MODE;
    mprv = 1'b0;
    ren = 1'b0;
    wen = 1'b0;
    xen = 1'b0;
    daddr = '0;
    iaddr = '0;
    repeat (16) @(posedge CLK);
    nRST <= 1'b1;

    // Write rules and readback, no locks yet
    repeat (N_RULES) begin
      a = pmp_pkg::PMPCFG_BASE + 12'(next_rand() % (NUM_ENTRIES / 4));
      csr_any(a, 1'b1, next_rand() & 32'h7f7f_7f7f);
      csr_any(a, 1'b0, '0);
      a = pmp_pkg::PMPADDR_BASE + 12'(next_rand() % NUM_ENTRIES);
      csr_any(a, 1'b1, next_rand());
      csr_any(a, 1'b0, '0);
    end

    configure_regions();
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      for (int k = 0; k < 4; k++) begin
        d = next_rand();
        drive_access(near_bound(i, k, d[1:0]), near_bound(i, k, d[3:2]));
      end
    end
    random_accesses(N_RAND);

    for (int n = 0; n < N_LOCK; n++) begin
      lock_entry(n);
      random_accesses(N_LOCK_RAND);
    end

    // Unknown CSR addresses, then a full sweep to see nothing moved
    repeat (N_ERR) begin
      a = 12'(next_rand());
      if (csr_addr_valid(a)) begin
        a = 12'h3C0 | {8'h00, a[3:0]};
      end
      csr_any(a, 1'b1, next_rand());
    end
    for (int i = 0; i < NUM_ENTRIES / 4; i++) begin
      csr_any(pmp_pkg::PMPCFG_BASE + 12'(i), 1'b0, '0);
    end
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      csr_any(pmp_pkg::PMPADDR_BASE + 12'(i), 1'b0, '0);
    end

    // Both ports at once, different registers
    repeat (N_ARB) begin
      j  = next_rand() % NUM_ENTRIES;
      c  = next_rand() % (NUM_ENTRIES / 4);
      d  = next_rand();
      we = next_rand() % 2 != 0;
      fork
        csr_check(1'b0, pmp_pkg::PMPADDR_BASE + 12'(j), we, d);
        csr_check(1'b1, pmp_pkg::PMPCFG_BASE + 12'(c), 1'b0, '0);
      join
    end

    $display("Errors: %0d CSR, %0d load/store, %0d fetch", errs[0], errs[1], errs[2]);
    if (errs[0] + errs[1] + errs[2] == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire
